// ==== rtl/sb_pkg.sv ====
package sb_pkg;

    parameter int xlen                = 32;
    parameter int rob_depth_default   = 16;
    parameter int stall_level_default = 12;

    typedef logic [4:0] reg_idx_t;
    typedef logic [3:0] rob_idx_t;

    typedef enum logic {
        fu_alu_id = 1'b0,
        fu_bru_id = 1'b1
    } fu_t;

    // msb marks a pending producer, lsb is its fu_t
    typedef enum logic [1:0] {
        tag_none = 2'b00,
        tag_alu  = 2'b10,
        tag_bru  = 2'b11
    } tag_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_t;

    typedef enum logic [3:0] {
        bru_beq,
        bru_bne,
        bru_jal
    } bru_op_t;

    // decoded by whichever unit the instruction was sent to
    typedef union packed {
        alu_op_t alu;
        bru_op_t bru;
    } op_u;

    typedef struct packed {
        logic [xlen-1:0] pc;
        fu_t             fu;
        op_u             op;
        logic            rs_valid;
        reg_idx_t        rs;
        logic            rt_valid;
        reg_idx_t        rt;
        logic            use_imm;
        logic [15:0]     imm;
        reg_idx_t        rd;
    } inst_t;

    typedef struct packed {
        logic            valid;
        rob_idx_t        rob;
        op_u             op;
        logic            use_imm;
        logic [15:0]     imm;
        logic [xlen-1:0] pc;
    } fu_req_t;

    typedef struct packed {
        logic            valid;
        rob_idx_t        rob;
        logic            rf_we;
        logic [xlen-1:0] wdata;
        logic            taken;
        logic [xlen-1:0] target;
    } fu_result_t;

    typedef struct packed {
        logic            valid;
        fu_t             fu;
        logic            rf_we;
        reg_idx_t        rd;
        logic [xlen-1:0] wdata;
    } retire_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic            we;
        reg_idx_t        wnum;
        logic [xlen-1:0] wdata;
    } commit_t;

endpackage

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                    clk,
    input  logic                    resetn,
    input  sb_pkg::reg_idx_t        raddr [4],
    input  sb_pkg::retire_t         retire,
    output logic [sb_pkg::xlen-1:0] rdata [4]
);

    // reg 0 has no storage
    logic [sb_pkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int r = 1; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else if (retire.valid && retire.rf_we && retire.rd != '0) begin
            regs[retire.rd] <= retire.wdata;
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rdata[p] = (raddr[p] == '0) ? '0 : regs[raddr[p]];
        end
    end

endmodule

// ==== rtl/fu_alu.sv ====
`timescale 1ns/1ps

module fu_alu (
    input  logic                    clk,
    input  logic                    resetn,
    input  sb_pkg::fu_req_t         req,
    input  logic [sb_pkg::xlen-1:0] rdata1,
    input  logic [sb_pkg::xlen-1:0] rdata2,
    output sb_pkg::fu_result_t      res
);

    logic [sb_pkg::xlen-1:0] opb;
    logic [sb_pkg::xlen-1:0] result;

    assign opb = req.use_imm ? {{(sb_pkg::xlen-16){req.imm[15]}}, req.imm} : rdata2;

    always_comb begin
        case (req.op.alu)
            sb_pkg::alu_add: result = rdata1 + opb;
            sb_pkg::alu_sub: result = rdata1 - opb;
            sb_pkg::alu_and: result = rdata1 & opb;
            sb_pkg::alu_or:  result = rdata1 | opb;
            sb_pkg::alu_xor: result = rdata1 ^ opb;
            sb_pkg::alu_slt: result = {{(sb_pkg::xlen-1){1'b0}}, $signed(rdata1) < $signed(opb)};
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        res.rob    <= req.rob;
        res.rf_we  <= 1'b1;
        res.wdata  <= result;
        res.taken  <= 1'b0;
        res.target <= '0;
        if (!resetn) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= req.valid;
        end
    end

endmodule

// ==== rtl/fu_bru.sv ====
`timescale 1ns/1ps

module fu_bru (
    input  logic                    clk,
    input  logic                    resetn,
    input  sb_pkg::fu_req_t         req,
    input  logic [sb_pkg::xlen-1:0] rdata1,
    input  logic [sb_pkg::xlen-1:0] rdata2,
    output sb_pkg::fu_result_t      res
);

    logic [sb_pkg::xlen-1:0] offset;
    logic [sb_pkg::xlen-1:0] target;
    logic                    taken;

    // word offset from the next pc
    assign offset = {{(sb_pkg::xlen-18){req.imm[15]}}, req.imm, 2'b00};
    assign target = req.pc + sb_pkg::xlen'(4) + offset;

    always_comb begin
        case (req.op.bru)
            sb_pkg::bru_beq: taken = (rdata1 == rdata2);
            sb_pkg::bru_bne: taken = (rdata1 != rdata2);
            sb_pkg::bru_jal: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        res.rob    <= req.rob;
        // only jal links
        res.rf_we  <= (req.op.bru == sb_pkg::bru_jal);
        res.wdata  <= req.pc + sb_pkg::xlen'(8);
        res.taken  <= taken;
        res.target <= target;
        if (!resetn) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= req.valid;
        end
    end

endmodule

// ==== rtl/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl #(
    parameter int ROB_DEPTH = 16
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             disp_valid,
    input  sb_pkg::inst_t    disp_entry,
    input  sb_pkg::rob_idx_t disp_idx,
    input  sb_pkg::retire_t  retire,
    input  logic             flush,
    output logic             disp_fire,
    output sb_pkg::fu_req_t  alu_req,
    output sb_pkg::fu_req_t  bru_req,
    output sb_pkg::reg_idx_t raddr [4]
);

    typedef struct packed {
        logic                    busy;
        logic                    issued;
        sb_pkg::rob_idx_t        rob;
        sb_pkg::op_u             op;
        logic                    use_imm;
        logic [15:0]             imm;
        logic [sb_pkg::xlen-1:0] pc;
        sb_pkg::reg_idx_t        src1;
        sb_pkg::reg_idx_t        src2;
        sb_pkg::tag_t            tag1;
        sb_pkg::tag_t            tag2;
    } station_t;

    // one station per unit, indexed by fu_t
    station_t     stn [2];
    station_t     new_stn;
    sb_pkg::tag_t rstat [32];
    sb_pkg::tag_t new_tag;
    sb_pkg::tag_t ret_tag;
    logic [1:0]   req_v;

    function automatic sb_pkg::tag_t unit_tag(sb_pkg::fu_t fu);
        return sb_pkg::tag_t'({1'b1, fu});
    endfunction

    // producer retiring this very cycle counts as already written
    function automatic sb_pkg::tag_t live_tag(sb_pkg::tag_t t, logic rv, sb_pkg::tag_t rt);
        return (rv && t == rt) ? sb_pkg::tag_none : t;
    endfunction

    function automatic sb_pkg::fu_req_t make_req(station_t s, logic v);
        sb_pkg::fu_req_t r;
        r.valid   = v;
        r.rob     = s.rob;
        r.op      = s.op;
        r.use_imm = s.use_imm;
        r.imm     = s.imm;
        r.pc      = s.pc;
        return r;
    endfunction

    assign ret_tag = unit_tag(retire.fu);
    assign new_tag = unit_tag(disp_entry.fu);

    // reg 0 is never marked, so it never blocks
    assign disp_fire = disp_valid && !flush && !stn[disp_entry.fu].busy
                       && rstat[disp_entry.rd] == sb_pkg::tag_none;

    always_comb begin
        new_stn.busy    = 1'b1;
        new_stn.issued  = 1'b0;
        new_stn.rob     = disp_idx;
        new_stn.op      = disp_entry.op;
        new_stn.use_imm = disp_entry.use_imm;
        new_stn.imm     = disp_entry.imm;
        new_stn.pc      = disp_entry.pc;
        new_stn.src1    = disp_entry.rs_valid ? disp_entry.rs : '0;
        new_stn.src2    = disp_entry.rt_valid ? disp_entry.rt : '0;
        new_stn.tag1    = live_tag(rstat[new_stn.src1], retire.valid, ret_tag);
        new_stn.tag2    = live_tag(rstat[new_stn.src2], retire.valid, ret_tag);
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            req_v[i] = stn[i].busy && !stn[i].issued && !flush
                       && stn[i].tag1 == sb_pkg::tag_none
                       && stn[i].tag2 == sb_pkg::tag_none;
        end
    end

    assign alu_req = make_req(stn[sb_pkg::fu_alu_id], req_v[sb_pkg::fu_alu_id]);
    assign bru_req = make_req(stn[sb_pkg::fu_bru_id], req_v[sb_pkg::fu_bru_id]);

    assign raddr[0] = stn[sb_pkg::fu_alu_id].src1;
    assign raddr[1] = stn[sb_pkg::fu_alu_id].src2;
    assign raddr[2] = stn[sb_pkg::fu_bru_id].src1;
    assign raddr[3] = stn[sb_pkg::fu_bru_id].src2;

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            for (int i = 0; i < 2; i++) begin
                stn[i].busy   <= 1'b0;
                stn[i].issued <= 1'b0;
            end
            for (int r = 0; r < 32; r++) begin
                rstat[r] <= sb_pkg::tag_none;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (req_v[i]) begin
                    stn[i].issued <= 1'b1;
                end
                if (retire.valid && stn[i].tag1 == ret_tag) begin
                    stn[i].tag1 <= sb_pkg::tag_none;
                end
                if (retire.valid && stn[i].tag2 == ret_tag) begin
                    stn[i].tag2 <= sb_pkg::tag_none;
                end
            end
            if (retire.valid) begin
                stn[retire.fu].busy   <= 1'b0;
                stn[retire.fu].issued <= 1'b0;
                rstat[retire.rd]      <= sb_pkg::tag_none;
            end
            if (disp_fire) begin
                stn[disp_entry.fu] <= new_stn;
                if (disp_entry.rd != '0) begin
                    rstat[disp_entry.rd] <= new_tag;
                end
            end
        end
    end

    // a dispatched instruction never waits on its own unit
    a_dispatch: assert property (@(posedge clk) disable iff (!resetn)
        disp_fire |-> (new_stn.tag1 != new_tag && new_stn.tag2 != new_tag));

    // a station is never requested while its occupant retires
    for (genvar g = 0; g < 2; g++) begin : g_req_chk
        a_req_retire: assert property (@(posedge clk) disable iff (!resetn)
            req_v[g] |-> !(retire.valid && retire.fu == sb_pkg::fu_t'(g)));
    end

endmodule

// ==== rtl/rob_queue.sv ====
`timescale 1ns/1ps

module rob_queue #(
    parameter int ROB_DEPTH   = 16,
    parameter int STALL_LEVEL = 12
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               inst_valid,
    input  sb_pkg::inst_t      inst,
    input  logic               disp_fire,
    input  sb_pkg::fu_result_t alu_res,
    input  sb_pkg::fu_result_t bru_res,
    output logic               stall,
    output logic               disp_valid,
    output sb_pkg::inst_t      disp_entry,
    output sb_pkg::rob_idx_t   disp_idx,
    output sb_pkg::retire_t    retire,
    output logic               flush,
    output sb_pkg::redirect_t  br_bus,
    output sb_pkg::commit_t    commit
);

    localparam int IW = $clog2(ROB_DEPTH);

    sb_pkg::inst_t           ent [ROB_DEPTH];
    logic [sb_pkg::xlen-1:0] res_wdata [ROB_DEPTH];
    logic [sb_pkg::xlen-1:0] res_target [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]    res_we;
    logic [ROB_DEPTH-1:0]    res_taken;
    logic [ROB_DEPTH-1:0]    valid;
    logic [ROB_DEPTH-1:0]    dispatched;
    logic [ROB_DEPTH-1:0]    done;
    sb_pkg::fu_result_t      fu_res [2];

    // pointers carry a wrap bit above the index
    logic [IW:0]   wptr;
    logic [IW:0]   dptr;
    logic [IW:0]   rptr;
    logic [IW:0]   used;
    logic [IW:0]   used_next;
    logic [IW-1:0] widx;
    logic [IW-1:0] didx;
    logic [IW-1:0] head;
    logic          accept;
    logic          retire_en;
    logic          stall_r;

    assign widx = wptr[IW-1:0];
    assign didx = dptr[IW-1:0];
    assign head = rptr[IW-1:0];

    assign fu_res[0] = alu_res;
    assign fu_res[1] = bru_res;

    assign accept    = inst_valid & ~stall;
    assign retire_en = valid[head] & done[head];
    assign flush     = retire_en & res_taken[head];
    assign stall     = stall_r | flush;

    assign used      = wptr - rptr;
    assign used_next = used + (IW+1)'(accept) - (IW+1)'(retire_en);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stall_r <= 1'b0;
        end else begin
            stall_r <= !flush && (used_next > (IW+1)'(STALL_LEVEL));
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr <= '0;
            dptr <= '0;
            rptr <= '0;
        end else if (flush) begin
            // queue restarts right behind the retiring branch
            wptr <= rptr + 1'b1;
            dptr <= rptr + 1'b1;
            rptr <= rptr + 1'b1;
        end else begin
            if (accept) begin
                wptr <= wptr + 1'b1;
            end
            if (disp_fire) begin
                dptr <= dptr + 1'b1;
            end
            if (retire_en) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid      <= '0;
            dispatched <= '0;
            done       <= '0;
        end else begin
            if (accept) begin
                valid[widx]      <= 1'b1;
                dispatched[widx] <= 1'b0;
                done[widx]       <= 1'b0;
            end
            if (disp_fire) begin
                dispatched[didx] <= 1'b1;
            end
            // late results for squashed entries fall out here
            for (int u = 0; u < 2; u++) begin
                if (fu_res[u].valid && valid[fu_res[u].rob]) begin
                    done[fu_res[u].rob] <= 1'b1;
                end
            end
            if (retire_en) begin
                valid[head] <= 1'b0;
            end
            if (flush) begin
                valid <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ent[widx] <= inst;
        end
        for (int u = 0; u < 2; u++) begin
            if (fu_res[u].valid) begin
                res_wdata[fu_res[u].rob]  <= fu_res[u].wdata;
                res_target[fu_res[u].rob] <= fu_res[u].target;
                res_we[fu_res[u].rob]     <= fu_res[u].rf_we;
                res_taken[fu_res[u].rob]  <= fu_res[u].taken;
            end
        end
    end

    assign disp_valid = valid[didx] & ~dispatched[didx];
    assign disp_entry = ent[didx];
    assign disp_idx   = didx;

    assign retire.valid = retire_en;
    assign retire.fu    = ent[head].fu;
    assign retire.rf_we = res_we[head];
    assign retire.rd    = ent[head].rd;
    assign retire.wdata = res_wdata[head];

    assign br_bus.taken  = flush;
    assign br_bus.target = res_target[head];

    assign commit.valid = retire_en;
    assign commit.pc    = ent[head].pc;
    assign commit.we    = res_we[head] && (ent[head].rd != '0);
    assign commit.wnum  = ent[head].rd;
    assign commit.wdata = res_wdata[head];

    // a new entry never lands on a live one
    a_no_overwrite: assert property (@(posedge clk) disable iff (!resetn)
        accept |-> !valid[widx]);

    a_alu_res_dispatched: assert property (@(posedge clk) disable iff (!resetn)
        alu_res.valid |-> dispatched[alu_res.rob]);

    a_bru_res_dispatched: assert property (@(posedge clk) disable iff (!resetn)
        bru_res.valid |-> dispatched[bru_res.rob]);

endmodule

// ==== rtl/scoreboard.sv ====
`timescale 1ns/1ps

module scoreboard #(
    parameter int ROB_DEPTH   = sb_pkg::rob_depth_default,
    parameter int STALL_LEVEL = sb_pkg::stall_level_default
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              inst_valid,
    input  sb_pkg::inst_t     inst,
    output logic              stall,
    output sb_pkg::redirect_t br_bus,
    output sb_pkg::commit_t   commit
);

    logic                    disp_valid;
    logic                    disp_fire;
    sb_pkg::inst_t           disp_entry;
    sb_pkg::rob_idx_t        disp_idx;
    sb_pkg::retire_t         retire;
    logic                    flush;
    sb_pkg::fu_req_t         alu_req;
    sb_pkg::fu_req_t         bru_req;
    sb_pkg::fu_result_t      alu_res;
    sb_pkg::fu_result_t      bru_res;
    sb_pkg::reg_idx_t        raddr [4];
    logic [sb_pkg::xlen-1:0] rdata [4];

    rob_queue #(
        .ROB_DEPTH   (ROB_DEPTH),
        .STALL_LEVEL (STALL_LEVEL)
    ) i_rob (
        .clk        (clk),
        .resetn     (resetn),
        .inst_valid (inst_valid),
        .inst       (inst),
        .disp_fire  (disp_fire),
        .alu_res    (alu_res),
        .bru_res    (bru_res),
        .stall      (stall),
        .disp_valid (disp_valid),
        .disp_entry (disp_entry),
        .disp_idx   (disp_idx),
        .retire     (retire),
        .flush      (flush),
        .br_bus     (br_bus),
        .commit     (commit)
    );

    issue_ctrl #(
        .ROB_DEPTH (ROB_DEPTH)
    ) i_issue (
        .clk        (clk),
        .resetn     (resetn),
        .disp_valid (disp_valid),
        .disp_entry (disp_entry),
        .disp_idx   (disp_idx),
        .retire     (retire),
        .flush      (flush),
        .disp_fire  (disp_fire),
        .alu_req    (alu_req),
        .bru_req    (bru_req),
        .raddr      (raddr)
    );

    // ports 0 and 1 serve the alu station, 2 and 3 the branch station
    fu_alu i_alu (
        .clk    (clk),
        .resetn (resetn),
        .req    (alu_req),
        .rdata1 (rdata[0]),
        .rdata2 (rdata[1]),
        .res    (alu_res)
    );

    fu_bru i_bru (
        .clk    (clk),
        .resetn (resetn),
        .req    (bru_req),
        .rdata1 (rdata[2]),
        .rdata2 (rdata[3]),
        .res    (bru_res)
    );

    regfile i_rf (
        .clk    (clk),
        .resetn (resetn),
        .raddr  (raddr),
        .retire (retire),
        .rdata  (rdata)
    );

endmodule

// ==== verif/tb_scoreboard.sv ====
`timescale 1ns/1ps

module tb_scoreboard;

    localparam int max_rows = 64;
    localparam int n_burst  = 10;
    localparam int n_random = 24;

    // one program row with the values the reference model expects at its commit
    typedef struct packed {
        sb_pkg::inst_t inst;
        logic          writes;
        logic [31:0]   wdata;
        logic          taken;
        logic [31:0]   target;
    } row_t;

    logic              clk;
    logic              resetn;
    logic              inst_valid;
    sb_pkg::inst_t     inst;
    logic              stall;
    sb_pkg::redirect_t br_bus;
    sb_pkg::commit_t   commit;

    row_t        rows [max_rows];
    int          n_rows;
    int          n_exp;
    int          exp_order [$];
    int          err_count;
    int          commit_count;
    int          in_use;
    logic        stall_seen;
    logic [31:0] rng;
    logic [31:0] fpc;

    scoreboard #(
        .ROB_DEPTH   (sb_pkg::rob_depth_default),
        .STALL_LEVEL (sb_pkg::stall_level_default)
    ) i_dut (
        .clk        (clk),
        .resetn     (resetn),
        .inst_valid (inst_valid),
        .inst       (inst),
        .stall      (stall),
        .br_bus     (br_bus),
        .commit     (commit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic sb_pkg::inst_t alu_inst(sb_pkg::alu_op_t op, sb_pkg::reg_idx_t rd,
                                               sb_pkg::reg_idx_t rs, sb_pkg::reg_idx_t rt,
                                               logic use_imm, logic [15:0] imm);
        sb_pkg::inst_t i;
        i          = '0;
        i.fu       = sb_pkg::fu_alu_id;
        i.op.alu   = op;
        i.rs_valid = 1'b1;
        i.rs       = rs;
        i.rt_valid = !use_imm;
        i.rt       = use_imm ? 5'd0 : rt;
        i.use_imm  = use_imm;
        i.imm      = imm;
        i.rd       = rd;
        return i;
    endfunction

    function automatic sb_pkg::inst_t bru_inst(sb_pkg::bru_op_t op, sb_pkg::reg_idx_t rs,
                                               sb_pkg::reg_idx_t rt, logic [15:0] imm,
                                               sb_pkg::reg_idx_t rd);
        sb_pkg::inst_t i;
        i          = '0;
        i.fu       = sb_pkg::fu_bru_id;
        i.op.bru   = op;
        // jal reads no register
        i.rs_valid = (op != sb_pkg::bru_jal);
        i.rs       = rs;
        i.rt_valid = (op != sb_pkg::bru_jal);
        i.rt       = rt;
        i.imm      = imm;
        i.rd       = rd;
        return i;
    endfunction

    task automatic add_row(input sb_pkg::inst_t i);
        rows[n_rows]         = '0;
        rows[n_rows].inst    = i;
        rows[n_rows].inst.pc = 32'(n_rows * 4);
        n_rows++;
    endtask

    task automatic build_program();
        logic [31:0]     r;
        logic [31:0]     s;
        sb_pkg::alu_op_t op;
        n_rows = 0;
        rng    = 32'hd79a;
        add_row(alu_inst(sb_pkg::alu_add, 5'd1, 5'd0, 5'd0, 1'b1, 16'd5));
        add_row(alu_inst(sb_pkg::alu_add, 5'd2, 5'd0, 5'd0, 1'b1, 16'hfffd));
        add_row(alu_inst(sb_pkg::alu_add, 5'd3, 5'd1, 5'd2, 1'b0, 16'd0));
        add_row(alu_inst(sb_pkg::alu_sub, 5'd4, 5'd1, 5'd2, 1'b0, 16'd0));
        add_row(alu_inst(sb_pkg::alu_and, 5'd5, 5'd1, 5'd2, 1'b0, 16'd0));
        add_row(alu_inst(sb_pkg::alu_or, 5'd6, 5'd1, 5'd2, 1'b0, 16'd0));
        add_row(alu_inst(sb_pkg::alu_xor, 5'd7, 5'd1, 5'd2, 1'b0, 16'd0));
        add_row(alu_inst(sb_pkg::alu_slt, 5'd8, 5'd2, 5'd1, 1'b0, 16'd0));
        add_row(alu_inst(sb_pkg::alu_slt, 5'd9, 5'd1, 5'd0, 1'b1, 16'hffff));
        add_row(alu_inst(sb_pkg::alu_add, 5'd0, 5'd1, 5'd0, 1'b1, 16'd7));
        // raw chain through r10 to r12
        add_row(alu_inst(sb_pkg::alu_add, 5'd10, 5'd1, 5'd0, 1'b1, 16'd1));
        add_row(alu_inst(sb_pkg::alu_add, 5'd10, 5'd10, 5'd10, 1'b0, 16'd0));
        add_row(alu_inst(sb_pkg::alu_sub, 5'd11, 5'd10, 5'd1, 1'b0, 16'd0));
        add_row(alu_inst(sb_pkg::alu_xor, 5'd12, 5'd11, 5'd10, 1'b0, 16'd0));
        // branch waits on the alu tag of r12, a stale read would take it
        add_row(bru_inst(sb_pkg::bru_beq, 5'd12, 5'd0, 16'd0, 5'd0));
        // waw on r13 around a not-taken bne
        add_row(alu_inst(sb_pkg::alu_add, 5'd13, 5'd0, 5'd0, 1'b1, 16'd100));
        add_row(bru_inst(sb_pkg::bru_bne, 5'd1, 5'd1, 16'd3, 5'd0));
        add_row(alu_inst(sb_pkg::alu_add, 5'd14, 5'd13, 5'd1, 1'b0, 16'd0));
        add_row(alu_inst(sb_pkg::alu_add, 5'd13, 5'd0, 5'd0, 1'b1, 16'd200));
        add_row(alu_inst(sb_pkg::alu_add, 5'd15, 5'd13, 5'd14, 1'b0, 16'd0));
        // taken beq and jal, each followed by wrong-path rows
        add_row(bru_inst(sb_pkg::bru_beq, 5'd1, 5'd1, 16'd2, 5'd0));
        add_row(alu_inst(sb_pkg::alu_add, 5'd16, 5'd0, 5'd0, 1'b1, 16'd1));
        add_row(alu_inst(sb_pkg::alu_add, 5'd17, 5'd0, 5'd0, 1'b1, 16'd2));
        add_row(bru_inst(sb_pkg::bru_jal, 5'd0, 5'd0, 16'd1, 5'd31));
        add_row(alu_inst(sb_pkg::alu_add, 5'd16, 5'd0, 5'd0, 1'b1, 16'd3));
        add_row(alu_inst(sb_pkg::alu_add, 5'd18, 5'd31, 5'd1, 1'b0, 16'd0));
        add_row(bru_inst(sb_pkg::bru_beq, 5'd1, 5'd2, 16'd5, 5'd0));
        for (int k = 0; k < n_burst; k++) begin
            add_row(alu_inst(sb_pkg::alu_add, 5'(20 + k), 5'd0, 5'd0, 1'b1, 16'(3 * k + 1)));
        end
        for (int k = 0; k < n_random; k++) begin
            rng = xorshift(rng);
            r   = rng;
            rng = xorshift(rng);
            s   = rng;
            op  = sb_pkg::alu_op_t'(4'(r % 6));
            add_row(alu_inst(op, 5'(1 + r[7:4] % 12), 5'(1 + r[11:8] % 12),
                             5'(1 + r[15:12] % 12), r[16], s[15:0]));
        end
    endtask

    // sequential execution of the table, in program order
    task automatic run_model();
        logic [31:0]   regs [32];
        logic [31:0]   pc;
        logic [31:0]   a;
        logic [31:0]   b;
        logic [31:0]   opb;
        logic [31:0]   simm;
        logic [31:0]   res;
        logic          tk;
        logic          we;
        int            idx;
        int            steps;
        sb_pkg::inst_t in;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc    = '0;
        steps = 0;
        while (int'(pc >> 2) < n_rows && steps < 256) begin
            idx  = int'(pc >> 2);
            in   = rows[idx].inst;
            a    = in.rs_valid ? regs[in.rs] : 32'd0;
            b    = in.rt_valid ? regs[in.rt] : 32'd0;
            simm = {{16{in.imm[15]}}, in.imm};
            tk   = 1'b0;
            we   = 1'b1;
            res  = '0;
            rows[idx].target = '0;
            if (in.fu == sb_pkg::fu_alu_id) begin
                opb = in.use_imm ? simm : b;
                case (in.op.alu)
                    sb_pkg::alu_add: res = a + opb;
                    sb_pkg::alu_sub: res = a - opb;
                    sb_pkg::alu_and: res = a & opb;
                    sb_pkg::alu_or:  res = a | opb;
                    sb_pkg::alu_xor: res = a ^ opb;
                    default:         res = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
                endcase
            end else begin
                rows[idx].target = pc + 32'd4 + (simm << 2);
                res = pc + 32'd8;
                we  = (in.op.bru == sb_pkg::bru_jal);
                case (in.op.bru)
                    sb_pkg::bru_beq: tk = (a == b);
                    sb_pkg::bru_bne: tk = (a != b);
                    default:         tk = 1'b1;
                endcase
            end
            rows[idx].wdata  = res;
            rows[idx].writes = we;
            rows[idx].taken  = tk;
            if (we && in.rd != 5'd0) begin
                regs[in.rd] = res;
            end
            exp_order.push_back(idx);
            pc = tk ? rows[idx].target : pc + 32'd4;
            steps++;
        end
    endtask

    task automatic check_commit(input sb_pkg::commit_t got, input sb_pkg::commit_t exp,
                                input logic chk_data);
        if (got.pc !== exp.pc) begin
            err_count++;
            $display("ERR commit.pc got %h exp %h", got.pc, exp.pc);
        end
        if (got.we !== exp.we) begin
            err_count++;
            $display("ERR commit.we got %h exp %h at pc %h", got.we, exp.we, exp.pc);
        end
        if (got.wnum !== exp.wnum) begin
            err_count++;
            $display("ERR commit.wnum got %h exp %h at pc %h", got.wnum, exp.wnum, exp.pc);
        end
        if (chk_data && got.wdata !== exp.wdata) begin
            err_count++;
            $display("ERR commit.wdata got %h exp %h at pc %h", got.wdata, exp.wdata, exp.pc);
        end
    endtask

    task automatic check_redirect(input sb_pkg::redirect_t got, input sb_pkg::redirect_t exp);
        if (got.taken !== exp.taken) begin
            err_count++;
            $display("ERR br_bus.taken got %h exp %h", got.taken, exp.taken);
        end
        if (exp.taken && got.target !== exp.target) begin
            err_count++;
            $display("ERR br_bus.target got %h exp %h", got.target, exp.target);
        end
    endtask

    task automatic print_counts();
        $display("commits %0d of %0d expected, errors %0d", commit_count, n_exp, err_count);
    endtask

    // fetch model, one instruction per accepted cycle
    always @(posedge clk) begin
        if (!resetn) begin
            fpc = '0;
            inst_valid <= 1'b0;
        end else begin
            if (br_bus.taken) begin
                fpc = br_bus.target;
            end else if (inst_valid && !stall) begin
                fpc = fpc + 32'd4;
            end
            if (int'(fpc >> 2) < n_rows) begin
                inst_valid <= 1'b1;
                inst       <= rows[fpc >> 2].inst;
            end else begin
                inst_valid <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        int                idx;
        sb_pkg::commit_t   exp_c;
        sb_pkg::redirect_t exp_r;
        if (resetn) begin
            if (commit.valid) begin
                commit_count++;
                if (exp_order.size() == 0) begin
                    err_count++;
                    $display("commit at pc %h came after the expected path ended", commit.pc);
                end else begin
                    idx          = exp_order.pop_front();
                    exp_c.valid  = 1'b1;
                    exp_c.pc     = rows[idx].inst.pc;
                    exp_c.we     = rows[idx].writes && rows[idx].inst.rd != 5'd0;
                    exp_c.wnum   = rows[idx].inst.rd;
                    exp_c.wdata  = rows[idx].wdata;
                    exp_r.taken  = rows[idx].taken;
                    exp_r.target = rows[idx].target;
                    check_commit(commit, exp_c, rows[idx].writes);
                    check_redirect(br_bus, exp_r);
                end
            end else if (br_bus.taken) begin
                err_count++;
                $display("branch redirect raised in a cycle without a commit");
            end
            if (stall && !br_bus.taken) begin
                stall_seen = 1'b1;
            end
            // queue occupancy after the coming edge
            if (br_bus.taken) begin
                in_use = 0;
            end else begin
                in_use = in_use + int'(inst_valid && !stall) - int'(commit.valid);
            end
            if (in_use >= 16) begin
                err_count++;
                $display("queue holds %0d entries and stall did not hold the source", in_use);
            end
        end
    end

    initial begin
        resetn       = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        err_count    = 0;
        commit_count = 0;
        in_use       = 0;
        stall_seen   = 1'b0;
        n_exp        = 0;
        build_program();
        run_model();
        n_exp = exp_order.size();
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        while (commit_count < n_exp) begin
            @(posedge clk);
        end
        // room for any commit beyond the expected path
        repeat (20) @(posedge clk);
        if (!stall_seen) begin
            err_count++;
            $display("stall was never raised during the instruction burst");
        end
        if (commit_count != n_exp) begin
            err_count++;
            $display("commit count differs from the executed path length");
        end
        print_counts();
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        wait (n_exp > 0);
        repeat (n_rows * 20 + 200) @(posedge clk);
        err_count++;
        $display("run did not complete within %0d cycles", n_rows * 20 + 200);
        print_counts();
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== scoreboard.f ====
rtl/sb_pkg.sv
rtl/regfile.sv
rtl/fu_alu.sv
rtl/fu_bru.sv
rtl/issue_ctrl.sv
rtl/rob_queue.sv
rtl/scoreboard.sv
verif/tb_scoreboard.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_scoreboard
FILELIST   := scoreboard.f
LINT_FLAGS := --lint-only --timing -sv
SIM_FLAGS  := --binary --timing --assert -sv -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
